//--- host_io.f
verilog/host_io_pkg.sv
verilog/host_word_port.sv
verilog/host_cmd_decoder.sv
verilog/ps2_device.sv
verilog/ps2_link.sv
verilog/host_io.sv
test/tb_clock.sv
test/host_io_tb.sv

//--- Bender.yml
package:
  name: host_io

sources:
  - verilog/host_io_pkg.sv
  - verilog/host_word_port.sv
  - verilog/host_cmd_decoder.sv
  - verilog/ps2_device.sv
  - verilog/ps2_link.sv
  - verilog/host_io.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/host_io_tb.sv

//--- test/host_io_tb.sv
//////////////////////////////////////////////////
// testbench for the host command bridge: random
// host frames checked against a register model,
// ps2 frames captured and compared per port
//////////////////////////////////////////////////
`timescale 1ns/100ps

module host_io_tb
	import host_io_pkg::*;
();

	localparam int NUM_FRAMES       = 60;
	localparam int WORD_GAP         = 6;
	localparam int FRAME_GAP        = 4;
	localparam int MAX_FRAME_CYCLES = 64;
	localparam int PS2_FRAME_CYCLES = 13 * 2 * PS2_HALF_PERIOD;
	localparam int FIFO_DEPTH       = 1 << PS2_FIFO_BITS;
	localparam int DRAIN_CYCLES     = 2 * FIFO_DEPTH * PS2_FRAME_CYCLES;
	localparam int WATCHDOG_CYCLES  = 16 + (NUM_FRAMES + 8) * MAX_FRAME_CYCLES + DRAIN_CYCLES;
	localparam int CLK_PERIOD_NS    = 40;
	localparam logic [31:0] LFSR_SEED = 32'h8c25_d560;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic       clk_100;
	logic       rst_n;
	logic       io_enable;
	logic       io_strobe;
	io_word_t   io_din;
	io_word_t   io_dout;
	status_t    status_in;
	logic       status_set;
	io_word_t   uart_mode;
	logic [1:0] buttons;
	io_word_t   joystick_0;
	io_word_t   joystick_1;
	status_t    status;
	logic       kbd_clk;
	logic       kbd_dat;
	logic       mouse_clk;
	logic       mouse_dat;

	// reference model state
	logic [1:0]  m_buttons;
	io_word_t    m_joy0;
	io_word_t    m_joy1;
	status_t     m_status;
	status_t     m_req;
	req_count_t  m_req_count;
	ps2_byte_t   kbd_q[$];
	ps2_byte_t   mouse_q[$];
	logic [31:0] lfsr;

	int          checks = 0;
	int          value_errors = 0;
	int          ps2_errors = 0;
	logic [10:0] kbd_bits;
	logic [10:0] mouse_bits;
	int          kbd_nbits = 0;
	int          mouse_nbits = 0;

	tb_clock clock_gen (
		.clk_100 (clk_100),
		.rst_n   (rst_n)
	);

	host_io DUT (
		.clk_100    (clk_100),
		.rst_n      (rst_n),
		.io_enable  (io_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.io_dout    (io_dout),
		.status_in  (status_in),
		.status_set (status_set),
		.uart_mode  (uart_mode),
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.kbd_clk    (kbd_clk),
		.kbd_dat    (kbd_dat),
		.mouse_clk  (mouse_clk),
		.mouse_dat  (mouse_dat)
	);

	//////////////////////////////////////////////////
	// random numbers and small helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb) begin
			s = s ^ LFSR_TAPS;
		end
		return s;
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int nbits, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic cmd_code_t pick_cmd(input logic [2:0] sel);
		case (sel)
			3'd0: return CMD_CFG;
			3'd1: return CMD_JOY0;
			3'd2: return CMD_JOY1;
			3'd3: return CMD_MOUSE;
			3'd4: return CMD_KBD;
			3'd5: return CMD_STATUS;
			3'd6: return CMD_UART;
			default: return CMD_STATUS_REQ;
		endcase
	endfunction

	// n rising edges, then the usual drive offset
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_100);
		#2;
	endtask

	task automatic expect_value(input string what, input logic [63:0] got,
	                            input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_registers();
		expect_value("buttons", buttons, m_buttons);
		expect_value("joystick_0", joystick_0, m_joy0);
		expect_value("joystick_1", joystick_1, m_joy1);
		expect_value("status", status, m_status);
	endtask

	//////////////////////////////////////////////////
	// model and host frames
	//////////////////////////////////////////////////
	task automatic model_word(input cmd_code_t cmd, input int idx, input io_word_t data,
	                          output io_word_t reply);
		reply = '0;
		if (idx == 0) begin
			if (cmd == CMD_STATUS_REQ) begin
				reply = {STATUS_REQ_TAG, 8'h00, m_req_count};
			end
		end else begin
			case (cmd)
				CMD_CFG: m_buttons = data[1:0];
				CMD_JOY0: m_joy0 = data;
				CMD_JOY1: m_joy1 = data;
				CMD_KBD: kbd_q.push_back(data[7:0]);
				CMD_MOUSE: mouse_q.push_back(data[7:0]);
				CMD_UART: reply = uart_mode;
				CMD_STATUS: begin
					if (idx <= 4) begin
						m_status[(idx - 1) * 16 +: 16] = data;
					end
				end
				CMD_STATUS_REQ: begin
					if (idx <= 4) begin
						reply = m_req[(idx - 1) * 16 +: 16];
					end
				end
				default: ;
			endcase
		end
	endtask

	// reply is sampled where the next strobe would be
	task automatic send_word(input io_word_t data, input io_word_t reply, input string what);
		io_din    = data;
		io_strobe = 1'b1;
		wait_cycles(1);
		io_strobe = 1'b0;
		wait_cycles(WORD_GAP - 1);
		expect_value(what, io_dout, reply);
	endtask

	task automatic run_frame(input cmd_code_t cmd, input int ndata, input int gap);
		io_word_t    data;
		io_word_t    reply;
		logic [31:0] r;
		io_enable = 1'b1;
		wait_cycles(1);
		model_word(cmd, 0, cmd, reply);
		send_word(cmd, reply, "command word reply");
		for (int i = 1; i <= ndata; i++) begin
			draw_bits(16, r);
			data = r[15:0];
			model_word(cmd, i, data, reply);
			send_word(data, reply, "data word reply");
		end
		io_enable = 1'b0;
		wait_cycles(gap);
		compare_registers();
	endtask

	task automatic pulse_status_set();
		logic [31:0] lo;
		logic [31:0] hi;
		draw_bits(32, lo);
		draw_bits(32, hi);
		status_in = {hi, lo};
		wait_cycles(1);
		status_set = 1'b1;
		wait_cycles(2);
		status_set = 1'b0;
		m_req = status_in;
		m_req_count++;
		wait_cycles(1);
	endtask

	//////////////////////////////////////////////////
	// ps2 capture, sampled on falling clock edges
	//////////////////////////////////////////////////
	task automatic inspect_ps2_frame(input string port_name, input logic [10:0] bits,
	                                 input ps2_byte_t exp);
		checks++;
		if (bits[0] !== 1'b0 || bits[8:1] !== exp || bits[9] !== ~^exp || bits[10] !== 1'b1) begin
			ps2_errors++;
			$display("Fail %0t: %s frame %b, expected byte %h", $time, port_name, bits, exp);
		end
	endtask

	always @(negedge kbd_clk) begin
		if (rst_n) begin
			kbd_bits = {kbd_dat, kbd_bits[10:1]};
			kbd_nbits++;
			if (kbd_nbits == 11) begin
				kbd_nbits = 0;
				if (kbd_q.size() == 0) begin
					ps2_errors++;
					$display("keyboard port sent a frame that the host never wrote");
				end else begin
					inspect_ps2_frame("keyboard", kbd_bits, kbd_q.pop_front());
				end
			end
		end
	end

	always @(negedge mouse_clk) begin
		if (rst_n) begin
			mouse_bits = {mouse_dat, mouse_bits[10:1]};
			mouse_nbits++;
			if (mouse_nbits == 11) begin
				mouse_nbits = 0;
				if (mouse_q.size() == 0) begin
					ps2_errors++;
					$display("mouse port sent a frame that the host never wrote");
				end else begin
					inspect_ps2_frame("mouse", mouse_bits, mouse_q.pop_front());
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD_NS);
		$display("watchdog expired before the test sequence finished");
		$display("checks %0d, value errors %0d, ps2 errors %0d", checks, value_errors, ps2_errors);
		$display("Errors found");
		$finish;
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin : main_seq
		cmd_code_t   cmd;
		logic [31:0] r;
		int          ndata;
		int          room;
		io_enable   = 1'b0;
		io_strobe   = 1'b0;
		io_din      = '0;
		status_in   = '0;
		status_set  = 1'b0;
		uart_mode   = '0;
		m_buttons   = '0;
		m_joy0      = '0;
		m_joy1      = '0;
		m_status    = '0;
		m_req       = '0;
		m_req_count = '0;
		lfsr        = LFSR_SEED;

		@(posedge rst_n);
		wait_cycles(1);
		expect_value("io_dout after reset", io_dout, 0);
		compare_registers();
		expect_value("ps2 lines after reset", {kbd_clk, kbd_dat, mouse_clk, mouse_dat}, 4'hF);

		for (int f = 0; f < NUM_FRAMES; f++) begin
			draw_bits(2, r);
			if (r[1:0] == 2'd0) begin
				pulse_status_set();
			end
			draw_bits(16, r);
			uart_mode = r[15:0];
			draw_bits(3, r);
			cmd = pick_cmd(r[2:0]);
			draw_bits(3, r);
			ndata = r[2:0] % 6;
			// keep each device fifo within its depth
			room = FIFO_DEPTH - ((cmd == CMD_KBD) ? kbd_q.size() : mouse_q.size());
			if ((cmd == CMD_KBD || cmd == CMD_MOUSE) && ndata > room) begin
				ndata = room;
			end
			run_frame(cmd, ndata, FRAME_GAP);
		end

		// full status frame, then one cut short by a one cycle enable drop
		run_frame(CMD_STATUS, 4, FRAME_GAP);
		run_frame(CMD_STATUS, 2, 1);
		run_frame(CMD_JOY1, 1, FRAME_GAP);
		pulse_status_set();
		run_frame(CMD_STATUS_REQ, 4, FRAME_GAP);

		while (kbd_q.size() + mouse_q.size() != 0) begin
			@(posedge clk_100);
		end
		wait_cycles(4 * PS2_HALF_PERIOD);
		expect_value("ps2 lines after drain", {kbd_clk, kbd_dat, mouse_clk, mouse_dat}, 4'hF);

		$display("checks %0d, value errors %0d, ps2 errors %0d", checks, value_errors, ps2_errors);
		if (value_errors + ps2_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- test/tb_clock.sv
//////////////////////////////////////////////////
// testbench clock and reset, 40 ns clock with
// reset held low for the first 16 cycles
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_clock (
	output logic clk_100,
	output logic rst_n
);

	localparam int HALF_PERIOD_NS = 20;
	localparam int RESET_CYCLES   = 16;

	initial begin
		clk_100 = 1'b0;
		forever #(HALF_PERIOD_NS) clk_100 = ~clk_100;
	end

	// release just after an edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_100);
		#2;
		rst_n = 1'b1;
	end

endmodule

//--- verilog/host_io.sv
//////////////////////////////////////////////////
// host command bridge top level: host word port,
// command decoder and ps2 link wired together
//////////////////////////////////////////////////
`timescale 1ns/100ps

module host_io
	import host_io_pkg::*;
(
	input  logic       clk_100,
	input  logic       rst_n,
	input  logic       io_enable,
	input  logic       io_strobe,
	input  io_word_t   io_din,
	output io_word_t   io_dout,
	input  status_t    status_in,
	input  logic       status_set,
	input  io_word_t   uart_mode,
	output logic [1:0] buttons,
	output io_word_t   joystick_0,
	output io_word_t   joystick_1,
	output status_t    status,
	output logic       kbd_clk,
	output logic       kbd_dat,
	output logic       mouse_clk,
	output logic       mouse_dat
);

	host_word_t word;
	ps2_write_t ps2_wr;

	host_word_port u_word_port (
		.clk_100   (clk_100),
		.rst_n     (rst_n),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.word      (word)
	);

	host_cmd_decoder u_decoder (
		.clk_100    (clk_100),
		.rst_n      (rst_n),
		.word       (word),
		.status_in  (status_in),
		.status_set (status_set),
		.uart_mode  (uart_mode),
		.io_dout    (io_dout),
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.ps2_wr     (ps2_wr)
	);

	ps2_link u_ps2_link (
		.clk_100   (clk_100),
		.rst_n     (rst_n),
		.ps2_wr    (ps2_wr),
		.kbd_clk   (kbd_clk),
		.kbd_dat   (kbd_dat),
		.mouse_clk (mouse_clk),
		.mouse_dat (mouse_dat)
	);

endmodule

//--- verilog/ps2_link.sv
//////////////////////////////////////////////////
// ps2 output side: makes the shared ps2 clock and
// steers byte writes to the keyboard or the mouse
//////////////////////////////////////////////////
`timescale 1ns/100ps

module ps2_link
	import host_io_pkg::*;
(
	input  logic       clk_100,
	input  logic       rst_n,
	input  ps2_write_t ps2_wr,
	output logic       kbd_clk,
	output logic       kbd_dat,
	output logic       mouse_clk,
	output logic       mouse_dat
);

	logic [PS2_DIV_BITS-1:0] div_cnt;
	logic                    ps2_clk;
	logic                    kbd_we;
	logic                    mouse_we;

	// clock divider, toggles every half period
	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			ps2_clk <= 1'b0;
		end else if (div_cnt == PS2_DIV_BITS'(PS2_HALF_PERIOD - 1)) begin
			div_cnt <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign kbd_we   = ps2_wr.valid && (ps2_wr.port == PS2_KBD);
	assign mouse_we = ps2_wr.valid && (ps2_wr.port == PS2_MOUSE);

	ps2_device keyboard (
		.clk_100 (clk_100),
		.rst_n   (rst_n),
		.we      (kbd_we),
		.wdata   (ps2_wr.data),
		.ps2_clk (ps2_clk),
		.clk_out (kbd_clk),
		.dat_out (kbd_dat)
	);

	ps2_device mouse (
		.clk_100 (clk_100),
		.rst_n   (rst_n),
		.we      (mouse_we),
		.wdata   (ps2_wr.data),
		.ps2_clk (ps2_clk),
		.clk_out (mouse_clk),
		.dat_out (mouse_dat)
	);

endmodule

//--- verilog/ps2_device.sv
//////////////////////////////////////////////////
// ps2 device transmitter that queues bytes from
// the host in a small fifo and sends each one as
// an 11 bit frame timed by the shared ps2 clock
//////////////////////////////////////////////////
`timescale 1ns/100ps

module ps2_device
	import host_io_pkg::*;
(
	input  logic      clk_100,
	input  logic      rst_n,
	input  logic      we,
	input  ps2_byte_t wdata,
	input  logic      ps2_clk,
	output logic      clk_out,
	output logic      dat_out
);

	ps2_byte_t     fifo_mem [1 << PS2_FIFO_BITS];
	ps2_fifo_ptr_t wptr;
	ps2_fifo_ptr_t rptr;
	logic          fifo_empty;
	logic          fifo_full;
	logic          push;
	logic          pop;

	logic          ps2_clk_q;
	logic          clk_rise;
	logic          clk_fall;

	ps2_tx_state_e state;
	ps2_byte_t     tx_byte;
	logic [2:0]    bit_cnt;
	logic          parity;

	//////////////////////////////////////////////////
	// byte fifo
	//////////////////////////////////////////////////
	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[PS2_FIFO_BITS] != rptr[PS2_FIFO_BITS]) &&
	                    (wptr[PS2_FIFO_BITS-1:0] == rptr[PS2_FIFO_BITS-1:0]);

	// writes to a full fifo are lost
	assign push = we && !fifo_full;

	assign clk_rise = ps2_clk && !ps2_clk_q;
	assign clk_fall = !ps2_clk && ps2_clk_q;
	assign pop      = clk_rise && (state == TX_IDLE) && !fifo_empty;

	always_ff @(posedge clk_100) begin
		if (push) begin
			fifo_mem[wptr[PS2_FIFO_BITS-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	// shift register for the byte on the wire
	always_ff @(posedge clk_100) begin
		if (pop) begin
			tx_byte <= fifo_mem[rptr[PS2_FIFO_BITS-1:0]];
		end else if (clk_rise && state == TX_DATA) begin
			tx_byte <= tx_byte >> 1;
		end
	end

	//////////////////////////////////////////////////
	// frame serialiser
	//////////////////////////////////////////////////
	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			ps2_clk_q <= 1'b0;
			state     <= TX_IDLE;
			bit_cnt   <= '0;
			parity    <= 1'b0;
			clk_out   <= 1'b1;
			dat_out   <= 1'b1;
		end else begin
			ps2_clk_q <= ps2_clk;

			if (clk_rise) begin
				clk_out <= 1'b1;
				case (state)
					TX_IDLE: begin
						if (pop) begin
							// start bit
							dat_out <= 1'b0;
							parity  <= 1'b1;
							bit_cnt <= '0;
							state   <= TX_DATA;
						end
					end

					// eight data bits sent lsb first
					TX_DATA: begin
						dat_out <= tx_byte[0];
						parity  <= parity ^ tx_byte[0];
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= TX_PARITY;
						end
					end

					TX_PARITY: begin
						dat_out <= parity;
						bit_cnt <= '0;
						state   <= TX_STOP;
					end

					// stop bit is held for two rising edges
					// and bit_cnt marks the second one
					TX_STOP: begin
						dat_out <= 1'b1;
						if (bit_cnt == 3'd0) begin
							bit_cnt <= 3'd1;
						end else begin
							state <= TX_IDLE;
						end
					end

					default: state <= TX_IDLE;
				endcase
			end

			// receiver samples on the falling edge
			if (clk_fall) begin
				clk_out <= (state == TX_IDLE);
			end
		end
	end

endmodule

//--- verilog/host_cmd_decoder.sv
//////////////////////////////////////////////////
// command decoder: acts on each host word, keeps
// the config, joystick and status registers, loads
// the reply for the host and issues ps2 byte writes
//////////////////////////////////////////////////
`timescale 1ns/100ps

module host_cmd_decoder
	import host_io_pkg::*;
(
	input  logic       clk_100,
	input  logic       rst_n,
	input  host_word_t word,
	input  status_t    status_in,
	input  logic       status_set,
	input  io_word_t   uart_mode,
	output io_word_t   io_dout,
	output logic [1:0] buttons,
	output io_word_t   joystick_0,
	output io_word_t   joystick_1,
	output status_t    status,
	output ps2_write_t ps2_wr
);

	logic       status_set_q;
	status_t    status_req;
	req_count_t req_count;

	//////////////////////////////////////////////////
	// status request capture
	//////////////////////////////////////////////////
	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			status_set_q <= 1'b0;
			status_req   <= '0;
			req_count    <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				status_req <= status_in;
				req_count  <= req_count + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// command decode and reply
	//////////////////////////////////////////////////
	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			io_dout    <= '0;
			buttons    <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			ps2_wr     <= '0;
		end else begin
			ps2_wr.valid <= 1'b0;

			if (word.valid) begin
				// reply is zero unless the command defines one
				io_dout <= '0;

				if (word.first) begin
					if (word.cmd == CMD_STATUS_REQ) begin
						io_dout <= {STATUS_REQ_TAG, 8'h00, req_count};
					end
				end else begin
					case (word.cmd)
						CMD_CFG: begin
							buttons <= word.data[1:0];
						end

						CMD_JOY0: begin
							joystick_0 <= word.data;
						end

						CMD_JOY1: begin
							joystick_1 <= word.data;
						end

						// 64 bit status, low part first
						CMD_STATUS: begin
							case (word.index)
								10'd1: status[15:0]  <= word.data;
								10'd2: status[31:16] <= word.data;
								10'd3: status[47:32] <= word.data;
								10'd4: status[63:48] <= word.data;
								default: ;
							endcase
						end

						CMD_KBD,
						CMD_MOUSE: begin
							ps2_wr.valid <= 1'b1;
							ps2_wr.port  <= (word.cmd == CMD_KBD) ? PS2_KBD : PS2_MOUSE;
							ps2_wr.data  <= word.data[7:0];
						end

						CMD_UART: begin
							io_dout <= uart_mode;
						end

						// captured request read back in four parts
						CMD_STATUS_REQ: begin
							case (word.index)
								10'd1: io_dout <= status_req[15:0];
								10'd2: io_dout <= status_req[31:16];
								10'd3: io_dout <= status_req[47:32];
								10'd4: io_dout <= status_req[63:48];
								default: ;
							endcase
						end

						default: ;
					endcase
				end
			end
		end
	end

endmodule

//--- verilog/host_word_port.sv
//////////////////////////////////////////////////
// host bus input side: follows the frame enable,
// counts words and passes each strobed word on to
// the command decoder one cycle after the strobe
//////////////////////////////////////////////////
`timescale 1ns/100ps

module host_word_port
	import host_io_pkg::*;
(
	input  logic       clk_100,
	input  logic       rst_n,
	input  logic       io_enable,
	input  logic       io_strobe,
	input  io_word_t   io_din,
	output host_word_t word
);

	word_index_t index_q;
	cmd_code_t   cmd_q;
	logic        take;
	logic        at_start;

	// output word register
	logic        valid_q;
	logic        first_q;
	word_index_t word_index_q;
	cmd_code_t   word_cmd_q;
	io_word_t    data_q;

	assign take     = io_enable && io_strobe;
	assign at_start = (index_q == '0);

	//////////////////////////////////////////////////
	// frame position and command latch
	//////////////////////////////////////////////////
	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			index_q <= '0;
			cmd_q   <= cmd_code_t'(16'h0000);
		end else if (!io_enable) begin
			// frame closed, next word is a command
			index_q <= '0;
		end else if (io_strobe) begin
			// index sticks at its maximum on long frames
			if (!(&index_q)) begin
				index_q <= index_q + 1'b1;
			end
			if (at_start) begin
				cmd_q <= cmd_code_t'(io_din);
			end
		end
	end

	// single cycle valid per word
	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			first_q <= 1'b0;
		end else begin
			valid_q <= take;
			first_q <= take && at_start;
		end
	end

	always_ff @(posedge clk_100) begin
		if (take) begin
			word_index_q <= index_q;
			// command word carries its own code
			word_cmd_q   <= at_start ? cmd_code_t'(io_din) : cmd_q;
			data_q       <= io_din;
		end
	end

	assign word = '{
		valid: valid_q,
		first: first_q,
		index: word_index_q,
		cmd:   word_cmd_q,
		data:  data_q
	};

endmodule

//--- verilog/host_io_pkg.sv
//////////////////////////////////////////////////
// shared types and constants for the host command
// bridge, imported by wildcard in every module
//////////////////////////////////////////////////
package host_io_pkg;

	// plain vector types
	typedef logic [15:0] io_word_t;
	typedef logic [9:0]  word_index_t;
	typedef logic [63:0] status_t;
	typedef logic [7:0]  ps2_byte_t;
	typedef logic [3:0]  req_count_t;

	// host command codes, first word of a frame
	typedef enum logic [15:0] {
		CMD_CFG        = 16'h0001,
		CMD_JOY0       = 16'h0002,
		CMD_JOY1       = 16'h0003,
		CMD_MOUSE      = 16'h0004,
		CMD_KBD        = 16'h0005,
		CMD_STATUS     = 16'h001E,
		CMD_UART       = 16'h0028,
		CMD_STATUS_REQ = 16'h0029
	} cmd_code_t;

	// one delivered host word with its frame position
	typedef struct packed {
		logic        valid;
		logic        first;
		word_index_t index;
		cmd_code_t   cmd;
		io_word_t    data;
	} host_word_t;

	typedef enum logic {
		PS2_KBD,
		PS2_MOUSE
	} ps2_port_e;

	typedef struct packed {
		logic      valid;
		ps2_port_e port;
		ps2_byte_t data;
	} ps2_write_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} ps2_tx_state_e;

	// clk_100 cycles per half period of the ps2 clock
	localparam int PS2_HALF_PERIOD = 8;
	localparam int PS2_DIV_BITS    = $clog2(PS2_HALF_PERIOD + 1);

	// fifo depth is 2**PS2_FIFO_BITS, pointers carry one wrap bit
	localparam int PS2_FIFO_BITS = 4;
	typedef logic [PS2_FIFO_BITS:0] ps2_fifo_ptr_t;

	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

endpackage
